// File: logic/memsys_defines.svh
`ifndef MEMSYS_DEFINES_SVH
`define MEMSYS_DEFINES_SVH

// ram geometry, word addressed
`define RAM_ADDR_W 10
`define RAM_WORDS (1 << `RAM_ADDR_W)

// top address nibble picks the slave
`define REGION_HI 31
`define REGION_LO 28

`define RAM_REGION 4'h0
`define TIMER_REGION 4'h1

// read value for holes in the map
`define UNMAPPED_DATA 32'h0000_0000

`endif

// File: logic/bus_pkg.sv
package bus_pkg;

	typedef logic [31:0] word_t; // data word
	typedef logic [31:0] addr_t; // byte address

	// target of the current bus cycle
	typedef enum logic [1:0] {
		SEL_RAM,
		SEL_TIMER,
		SEL_NONE
	} slave_sel_e;

	// cpu step sequencing
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_FETCH,
		BR_DATA,
		BR_DONE
	} bridge_state_e;

endpackage

// File: logic/periph_pkg.sv
package periph_pkg;

	// register index from adr[3:2]
	typedef enum logic [1:0] {
		TMR_COUNT   = 2'd0,
		TMR_COMPARE = 2'd1,
		TMR_CTRL    = 2'd2,
		TMR_STATUS  = 2'd3
	} timer_reg_e;

	localparam int CTRL_EN_BIT = 0; // count enable
	localparam int CTRL_IE_BIT = 1; // irq enable

endpackage

// File: logic/cpu_bus_bridge.sv
`timescale 1ns/10ps

module cpu_bus_bridge (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            dm_en_i,
	input  logic            dm_wr_i,
	input  bus_pkg::addr_t  dm_adr_i,
	input  bus_pkg::word_t  dm_dat_i,
	input  bus_pkg::addr_t  im_adr_i,
	input  logic            bus_ack_i,
	input  bus_pkg::word_t  bus_rdat_i,
	output logic            cpu_pause_o,
	output bus_pkg::word_t  im_dat_o,
	output bus_pkg::word_t  dm_dat_o,
	output logic            bus_stb_o,
	output logic            bus_we_o,
	output bus_pkg::addr_t  bus_adr_o,
	output bus_pkg::word_t  bus_wdat_o
);

	bus_pkg::bridge_state_e state_q;
	bus_pkg::word_t         im_dat_q;
	bus_pkg::word_t         dm_dat_q;

	// step sequencer: fetch, optional data access, one release cycle
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= bus_pkg::BR_IDLE;
		end else begin
			case (state_q)
				bus_pkg::BR_IDLE: begin
					state_q <= bus_pkg::BR_FETCH;
				end
				bus_pkg::BR_FETCH: begin
					if (bus_ack_i) begin
						if (dm_en_i)
							state_q <= bus_pkg::BR_DATA;
						else
							state_q <= bus_pkg::BR_DONE;
					end
				end
				bus_pkg::BR_DATA: begin
					if (bus_ack_i)
						state_q <= bus_pkg::BR_DONE;
				end
				bus_pkg::BR_DONE: begin
					state_q <= bus_pkg::BR_FETCH; // cpu moves on this edge
				end
				default: begin
					state_q <= bus_pkg::BR_IDLE;
				end
			endcase
		end
	end

	// result words, held until the next matching ack
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			im_dat_q <= '0;
			dm_dat_q <= '0;
		end else begin
			if (state_q == bus_pkg::BR_FETCH && bus_ack_i)
				im_dat_q <= bus_rdat_i;
			if (state_q == bus_pkg::BR_DATA && bus_ack_i && !dm_wr_i)
				dm_dat_q <= bus_rdat_i; // writes keep old value
		end
	end

	always_comb begin
		bus_stb_o  = (state_q == bus_pkg::BR_FETCH) || (state_q == bus_pkg::BR_DATA);
		bus_we_o   = (state_q == bus_pkg::BR_DATA) && dm_wr_i;
		bus_wdat_o = dm_dat_i;
		if (state_q == bus_pkg::BR_DATA)
			bus_adr_o = dm_adr_i;
		else
			bus_adr_o = im_adr_i;
	end

	assign cpu_pause_o = (state_q != bus_pkg::BR_DONE);
	assign im_dat_o    = im_dat_q;
	assign dm_dat_o    = dm_dat_q;

endmodule

// File: logic/bus_decoder.sv
`timescale 1ns/10ps
`include "memsys_defines.svh"

module bus_decoder (
	input  logic            stb_i,
	input  logic            we_i,
	input  bus_pkg::addr_t  adr_i,
	input  bus_pkg::word_t  wdat_i,
	input  logic            ram_ack_i,
	input  bus_pkg::word_t  ram_rdat_i,
	input  logic            timer_ack_i,
	input  bus_pkg::word_t  timer_rdat_i,
	input  logic            clk_i,
	input  logic            arst_n_i,
	output logic            ack_o,
	output bus_pkg::word_t  rdat_o,
	output logic            ram_cs_o,
	output logic            timer_cs_o,
	output logic            slv_we_o,
	output bus_pkg::addr_t  slv_adr_o,
	output bus_pkg::word_t  slv_wdat_o
);

	logic [`REGION_HI-`REGION_LO:0] region;
	bus_pkg::slave_sel_e            sel;
	logic                           none_ack_q;

	assign region = adr_i[`REGION_HI:`REGION_LO];

	always_comb begin
		case (region)
			`RAM_REGION:   sel = bus_pkg::SEL_RAM;
			`TIMER_REGION: sel = bus_pkg::SEL_TIMER;
			default:       sel = bus_pkg::SEL_NONE;
		endcase
	end

	// self ack for holes in the map
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			none_ack_q <= 1'b0;
		else
			none_ack_q <= stb_i && (sel == bus_pkg::SEL_NONE) && !none_ack_q;
	end

	assign ram_cs_o   = stb_i && (sel == bus_pkg::SEL_RAM);
	assign timer_cs_o = stb_i && (sel == bus_pkg::SEL_TIMER);
	assign slv_we_o   = stb_i && we_i;
	assign slv_adr_o  = adr_i;
	assign slv_wdat_o = wdat_i;

	// return path
	always_comb begin
		case (sel)
			bus_pkg::SEL_RAM: begin
				ack_o  = ram_ack_i;
				rdat_o = ram_rdat_i;
			end
			bus_pkg::SEL_TIMER: begin
				ack_o  = timer_ack_i;
				rdat_o = timer_rdat_i;
			end
			default: begin
				ack_o  = none_ack_q;
				rdat_o = `UNMAPPED_DATA;
			end
		endcase
	end

endmodule

// File: logic/inter_ram.sv
`timescale 1ns/10ps
`include "memsys_defines.svh"

module inter_ram (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            cs_i,
	input  logic            we_i,
	input  bus_pkg::addr_t  adr_i,
	input  bus_pkg::word_t  dat_i,
	output logic            ack_o,
	output bus_pkg::word_t  dat_o
);

	bus_pkg::word_t          mem [0:`RAM_WORDS-1];
	logic [`RAM_ADDR_W-1:0]  word_idx;
	logic                    ack_q;
	bus_pkg::word_t          rdat_q;
	logic                    access;

	assign word_idx = adr_i[`RAM_ADDR_W+1:2]; // byte to word
	assign access   = cs_i && !ack_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= access; // single cycle pulse
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			if (we_i)
				mem[word_idx] <= dat_i;
			rdat_q <= mem[word_idx];
		end
	end

	assign ack_o = ack_q;
	assign dat_o = rdat_q;

endmodule

// File: logic/interval_timer.sv
`timescale 1ns/10ps

module interval_timer (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            cs_i,
	input  logic            we_i,
	input  bus_pkg::addr_t  adr_i,
	input  bus_pkg::word_t  dat_i,
	output logic            ack_o,
	output bus_pkg::word_t  dat_o,
	output logic            int_o
);

	periph_pkg::timer_reg_e             reg_sel;
	bus_pkg::word_t                     count_q;
	bus_pkg::word_t                     compare_q;
	logic [periph_pkg::CTRL_IE_BIT:0]   ctrl_q;
	logic                               pending_q;
	logic                               ack_q;
	bus_pkg::word_t                     rdat_q;
	logic                               access;
	logic                               wr;
	logic                               hit;

	assign reg_sel = periph_pkg::timer_reg_e'(adr_i[3:2]);
	assign access  = cs_i && !ack_q;
	assign wr      = access && we_i;
	assign hit     = ctrl_q[periph_pkg::CTRL_EN_BIT] && (count_q == compare_q);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_q   <= '0;
			compare_q <= '0;
			ctrl_q    <= '0;
			pending_q <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q <= access;
			if (ctrl_q[periph_pkg::CTRL_EN_BIT]) begin
				if (hit)
					count_q <= '0; // wrap on match
				else
					count_q <= count_q + 32'd1;
			end
			if (wr && reg_sel == periph_pkg::TMR_COMPARE)
				compare_q <= dat_i;
			if (wr && reg_sel == periph_pkg::TMR_CTRL)
				ctrl_q <= dat_i[periph_pkg::CTRL_IE_BIT:0];
			if (wr && reg_sel == periph_pkg::TMR_STATUS && dat_i[0])
				pending_q <= 1'b0; // w1c
			if (hit)
				pending_q <= 1'b1; // new match wins over clear
		end
	end

	// read data, valid in the ack cycle
	always_ff @(posedge clk_i) begin
		if (access) begin
			case (reg_sel)
				periph_pkg::TMR_COUNT:   rdat_q <= count_q;
				periph_pkg::TMR_COMPARE: rdat_q <= compare_q;
				periph_pkg::TMR_CTRL:    rdat_q <= 32'(ctrl_q);
				default:                 rdat_q <= {31'd0, pending_q};
			endcase
		end
	end

	assign ack_o = ack_q;
	assign dat_o = rdat_q;
	assign int_o = pending_q && ctrl_q[periph_pkg::CTRL_IE_BIT];

endmodule

// File: logic/memory_sys.sv
`timescale 1ns/10ps

module memory_sys (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            dm_en_i,
	input  logic            dm_wr_i,
	input  bus_pkg::addr_t  dm_adr_i,
	input  bus_pkg::addr_t  im_adr_i,
	input  bus_pkg::word_t  dm_dat_i,
	output logic            cpu_pause_o,
	output logic            int_o,
	output bus_pkg::word_t  dm_dat_o,
	output bus_pkg::word_t  im_dat_o
);

	// master side
	logic            bus_stb;
	logic            bus_we;
	bus_pkg::addr_t  bus_adr;
	bus_pkg::word_t  bus_wdat;
	logic            bus_ack;
	bus_pkg::word_t  bus_rdat;

	// slave side
	logic            ram_cs;
	logic            timer_cs;
	logic            slv_we;
	bus_pkg::addr_t  slv_adr;
	bus_pkg::word_t  slv_wdat;
	logic            ram_ack;
	bus_pkg::word_t  ram_rdat;
	logic            timer_ack;
	bus_pkg::word_t  timer_rdat;

	cpu_bus_bridge bridge_inst (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.dm_en_i     (dm_en_i),
		.dm_wr_i     (dm_wr_i),
		.dm_adr_i    (dm_adr_i),
		.dm_dat_i    (dm_dat_i),
		.im_adr_i    (im_adr_i),
		.bus_ack_i   (bus_ack),
		.bus_rdat_i  (bus_rdat),
		.cpu_pause_o (cpu_pause_o),
		.im_dat_o    (im_dat_o),
		.dm_dat_o    (dm_dat_o),
		.bus_stb_o   (bus_stb),
		.bus_we_o    (bus_we),
		.bus_adr_o   (bus_adr),
		.bus_wdat_o  (bus_wdat)
	);

	bus_decoder decoder_inst (
		.stb_i        (bus_stb),
		.we_i         (bus_we),
		.adr_i        (bus_adr),
		.wdat_i       (bus_wdat),
		.ram_ack_i    (ram_ack),
		.ram_rdat_i   (ram_rdat),
		.timer_ack_i  (timer_ack),
		.timer_rdat_i (timer_rdat),
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.ack_o        (bus_ack),
		.rdat_o       (bus_rdat),
		.ram_cs_o     (ram_cs),
		.timer_cs_o   (timer_cs),
		.slv_we_o     (slv_we),
		.slv_adr_o    (slv_adr),
		.slv_wdat_o   (slv_wdat)
	);

	inter_ram ram_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.cs_i     (ram_cs),
		.we_i     (slv_we),
		.adr_i    (slv_adr),
		.dat_i    (slv_wdat),
		.ack_o    (ram_ack),
		.dat_o    (ram_rdat)
	);

	interval_timer timer_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.cs_i     (timer_cs),
		.we_i     (slv_we),
		.adr_i    (slv_adr),
		.dat_i    (slv_wdat),
		.ack_o    (timer_ack),
		.dat_o    (timer_rdat),
		.int_o    (int_o) // only irq source
	);

endmodule

// File: sim/tb_memory_sys.sv
`timescale 1ns/10ps
`include "memsys_defines.svh"

module tb_memory_sys;

	localparam int             NUM_WORDS    = 16;
	localparam int             STEP_TIMEOUT = 50;  // cycles per cpu step
	localparam int             IRQ_TIMEOUT  = 200; // idle steps
	localparam bus_pkg::word_t TMR_CMP      = 32'd20;
	localparam bus_pkg::addr_t FETCH_ADR    = 32'h0000_0000; // ram word 0
	localparam bus_pkg::word_t CTRL_EN      = 32'd1 << periph_pkg::CTRL_EN_BIT;
	localparam bus_pkg::word_t CTRL_IE      = 32'd1 << periph_pkg::CTRL_IE_BIT;

	logic           clk_i;
	logic           arst_n_i;
	logic           dm_en_i;
	logic           dm_wr_i;
	bus_pkg::addr_t dm_adr_i;
	bus_pkg::addr_t im_adr_i;
	bus_pkg::word_t dm_dat_i;
	logic           cpu_pause_o;
	logic           int_o;
	bus_pkg::word_t dm_dat_o;
	bus_pkg::word_t im_dat_o;

	logic [31:0]    lfsr;
	bus_pkg::word_t shadow  [0:`RAM_WORDS-1]; // ram contents as written
	bit             written [0:`RAM_WORDS-1];
	bus_pkg::addr_t addrs   [NUM_WORDS];
	string          cur_test;
	logic           chk_on;
	logic           chk_im;
	logic           chk_dm;
	bus_pkg::word_t exp_im;
	bus_pkg::word_t exp_dm;
	bus_pkg::word_t last_dm; // last word a data read returned

	memory_sys memory_sys_inst (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.dm_en_i     (dm_en_i),
		.dm_wr_i     (dm_wr_i),
		.dm_adr_i    (dm_adr_i),
		.im_adr_i    (im_adr_i),
		.dm_dat_i    (dm_dat_i),
		.cpu_pause_o (cpu_pause_o),
		.int_o       (int_o),
		.dm_dat_o    (dm_dat_o),
		.im_dat_o    (im_dat_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]}; // one step per bit
		end
	endtask

	function automatic logic is_ram(input bus_pkg::addr_t a);
		return a[`REGION_HI:`REGION_LO] == `RAM_REGION;
	endfunction

	// expected read value for ram and unmapped space
	function automatic bus_pkg::word_t model_read(input bus_pkg::addr_t a);
		if (is_ram(a))
			return shadow[a[`RAM_ADDR_W+1:2]];
		return `UNMAPPED_DATA;
	endfunction

	function automatic bus_pkg::addr_t ram_addr(input logic [`RAM_ADDR_W-1:0] idx);
		bus_pkg::addr_t a;
		a = '0;
		a[`RAM_ADDR_W+1:2] = idx;
		return a;
	endfunction

	function automatic bus_pkg::addr_t timer_addr(input periph_pkg::timer_reg_e r);
		return {`TIMER_REGION, 24'd0, r, 2'b00};
	endfunction

	task automatic check_word(input string name, input bus_pkg::word_t exp,
			input bus_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic wait_release(input string name);
		int n;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (cpu_pause_o && n < STEP_TIMEOUT);
		if (cpu_pause_o) begin
			$display("timeout: cpu_pause_o stayed high during %s", name);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// one cpu step from the edge that ends the release cycle
	task automatic cpu_step(input string name, input logic en, input logic wr,
			input bus_pkg::addr_t adr, input bus_pkg::word_t wdat,
			input bus_pkg::addr_t iadr, input logic dm_known, input bus_pkg::word_t dm_exp);
		@(posedge clk_i);
		#2;
		cur_test = name;
		exp_im   = model_read(iadr); // fetch runs before the data access
		chk_im   = !is_ram(iadr) || written[iadr[`RAM_ADDR_W+1:2]];
		exp_dm   = dm_exp;
		chk_dm   = dm_known;
		chk_on   = 1'b1;
		dm_en_i  = en;
		dm_wr_i  = wr;
		dm_adr_i = adr;
		dm_dat_i = wdat;
		im_adr_i = iadr;
		if (en && wr && is_ram(adr)) begin
			shadow[adr[`RAM_ADDR_W+1:2]]  = wdat;
			written[adr[`RAM_ADDR_W+1:2]] = 1'b1;
		end
		wait_release(name);
	endtask

	task automatic write_step(input string name, input bus_pkg::addr_t adr,
			input bus_pkg::word_t wdat, input bus_pkg::addr_t iadr);
		cpu_step(name, 1'b1, 1'b1, adr, wdat, iadr, 1'b1, last_dm);
	endtask

	task automatic read_step(input string name, input bus_pkg::addr_t adr,
			input bus_pkg::addr_t iadr, input bus_pkg::word_t exp);
		cpu_step(name, 1'b1, 1'b0, adr, '0, iadr, 1'b1, exp);
		last_dm = exp;
	endtask

	task automatic idle_step(input string name, input bus_pkg::addr_t iadr);
		cpu_step(name, 1'b0, 1'b0, '0, '0, iadr, 1'b1, last_dm);
	endtask

	// compares both result words in every release cycle
	always @(negedge clk_i) begin
		if (chk_on && !cpu_pause_o) begin
			if (chk_im)
				check_word({cur_test, " im_dat_o"}, exp_im, im_dat_o);
			if (chk_dm)
				check_word({cur_test, " dm_dat_o"}, exp_dm, dm_dat_o);
		end
	end

	initial begin
		logic [31:0]    r;
		bus_pkg::addr_t ua;
		int             n;
		lfsr     = 32'h85af2d55;
		chk_on   = 1'b0;
		chk_im   = 1'b0;
		chk_dm   = 1'b0;
		last_dm  = '0;
		arst_n_i = 1'b0;
		dm_en_i  = 1'b0;
		dm_wr_i  = 1'b0;
		dm_adr_i = '0;
		im_adr_i = FETCH_ADR;
		dm_dat_i = '0;
		repeat (3) @(posedge clk_i);
		#2;
		check_bit("reset pause", 1'b1, cpu_pause_o);
		check_bit("reset irq", 1'b0, int_o);
		check_word("reset im_dat_o", '0, im_dat_o);
		arst_n_i = 1'b1;
		wait_release("reset release");
		check_word("reset dm_dat_o", '0, dm_dat_o);

		rand_bits(32, r);
		write_step("fetch word init", FETCH_ADR, r, FETCH_ADR);
		for (int i = 0; i < NUM_WORDS; i++) begin
			rand_bits(`RAM_ADDR_W, r);
			addrs[i] = ram_addr(r[`RAM_ADDR_W-1:0]);
			rand_bits(32, r);
			write_step("ram write", addrs[i], r, FETCH_ADR);
		end
		for (int i = 0; i < NUM_WORDS; i++)
			read_step("ram readback", addrs[i], addrs[i], model_read(addrs[i]));

		idle_step("no data access", addrs[0]);
		rand_bits(32, r);
		write_step("write keeps dm", addrs[1], r, addrs[1]);
		read_step("read after write", addrs[1], FETCH_ADR, model_read(addrs[1]));

		ua = {4'h7, addrs[3][27:0]}; // low bits alias a written ram word
		read_step("unmapped read", ua, FETCH_ADR, `UNMAPPED_DATA);
		ua = {4'h9, addrs[2][27:0]}; // same low bits as a ram word
		rand_bits(32, r);
		write_step("unmapped write", ua, r, FETCH_ADR);
		for (int i = 0; i < NUM_WORDS; i++)
			read_step("ram after unmapped write", addrs[i], addrs[i], model_read(addrs[i]));

		write_step("timer compare", timer_addr(periph_pkg::TMR_COMPARE), TMR_CMP, FETCH_ADR);
		write_step("timer ctrl", timer_addr(periph_pkg::TMR_CTRL), CTRL_EN | CTRL_IE, FETCH_ADR);
		n = 0;
		while (!int_o && n < IRQ_TIMEOUT) begin
			idle_step("timer irq wait", FETCH_ADR);
			n++;
		end
		if (!int_o) begin
			$display("timeout: timer interrupt never rose");
			$display("sim failed");
			$fatal(1);
		end
		read_step("timer status", timer_addr(periph_pkg::TMR_STATUS), FETCH_ADR, 32'd1);
		write_step("timer stop", timer_addr(periph_pkg::TMR_CTRL), CTRL_IE, FETCH_ADR);
		check_bit("irq held while stopped", 1'b1, int_o);
		write_step("timer clear", timer_addr(periph_pkg::TMR_STATUS), 32'd1, FETCH_ADR);
		idle_step("after clear", FETCH_ADR);
		check_bit("irq after clear", 1'b0, int_o);

		write_step("timer run no irq", timer_addr(periph_pkg::TMR_CTRL), CTRL_EN, FETCH_ADR);
		for (int i = 0; i < 2; i++) begin
			cpu_step("timer count", 1'b1, 1'b0, timer_addr(periph_pkg::TMR_COUNT), '0,
				FETCH_ADR, 1'b0, '0);
			check_bit("count within compare", 1'b1, dm_dat_o <= TMR_CMP);
		end

		@(posedge clk_i);
		$display("sim passed");
		$finish;
	end

endmodule

// File: memsys.f
+incdir+logic
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/cpu_bus_bridge.sv
logic/bus_decoder.sv
logic/inter_ram.sv
logic/interval_timer.sv
logic/memory_sys.sv
sim/tb_memory_sys.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module tb_memory_sys -f memsys.f -o tb_memory_sys

./obj_dir/tb_memory_sys | tee sim.log

if grep -q "sim passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
